// File: sim.f
hw/pe_pkg.sv
hw/multicaster.sv
hw/weight_buffer.sv
hw/pe_mac.sv
hw/pe_slot_top.sv
tb/pe_slot_checker.sv
tb/tb_pe_slot.sv

// File: Bender.yml
package:
  name: pe_slot

sources:
  # design, package first
  - files:
      - hw/pe_pkg.sv
      - hw/multicaster.sv
      - hw/weight_buffer.sv
      - hw/pe_mac.sv
      - hw/pe_slot_top.sv
  # simulation only
  - target: test
    files:
      - tb/pe_slot_checker.sv
      - tb/tb_pe_slot.sv

// File: tb/tb_pe_slot.sv
module tb_pe_slot import pe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 200;

    logic                  clk;
    logic                  rstn;
    cfg_t                  cfg;
    bus_word_t             bus_in;
    logic                  ready;
    logic                  kernel_busy;
    logic                  result_valid;
    logic [psum_width-1:0] result_psum;
    int                    pending;
    int                    error_count;
    logic [31:0]           rng_state;
    logic [id_width-1:0]   tag;
    int                    k;

    // 100 ns period
    always #50 clk = ~clk;

    pe_slot_top dut (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg),
        .bus_in       (bus_in),
        .ready        (ready),
        .kernel_busy  (kernel_busy),
        .result_valid (result_valid),
        .result_psum  (result_psum)
    );

    pe_slot_checker u_checker (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg),
        .bus_in       (bus_in),
        .ready        (ready),
        .kernel_busy  (kernel_busy),
        .result_valid (result_valid),
        .result_psum  (result_psum),
        .pending      (pending),
        .error_count  (error_count)
    );

    //////////////////////////////
    // random helpers
    //////////////////////////////

    // 32 bit xorshift
    function logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bus_word_t make_word(input pkt_kind_t kind, input logic [id_width-1:0] id);
        bus_word_t   w;
        logic [31:0] r;
        r       = xorshift();
        w       = '0;
        w.valid = 1'b1;
        w.kind  = kind;
        w.id    = id;
        w.ifmap = r[data_width-1:0];
        w.psum  = xorshift();
        return w;
    endfunction

    // another column with the broadcast bit clear
    function automatic logic [id_width-1:0] foreign_id();
        logic [31:0] r;
        r = xorshift();
        return id_width'((tag + 1 + r % (num_col - 1)) % num_col);
    endfunction

    // mode 0 is the own tag, 1 broadcast and 2 either
    function automatic logic [id_width-1:0] pick_id(input int mode);
        logic [31:0] r;
        r = xorshift();
        if (mode == 0 || (mode == 2 && r[8])) begin
            return tag;
        end
        return {1'b1, r[id_width-2:0]};
    endfunction

    //////////////////////////////
    // bus driving
    //////////////////////////////

    task automatic drive(input cfg_t c, input bus_word_t w);
        @(posedge clk);
        cfg    <= c;
        bus_in <= w;
    endtask

    task automatic idle(input int n);
        repeat (n) drive('0, '0);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $finish;
    endtask

    // outputs sampled on the falling edge
    task automatic wait_ready(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (ready !== level) begin
            if (n == wait_limit) begin
                abort_run($sformatf("ready did not go to %0b within %0d cycles", level, n));
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        @(negedge clk);
        while (pending != 0) begin
            if (n == wait_limit) begin
                abort_run($sformatf("%0d results still missing after %0d cycles", pending, n));
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic configure_tag();
        cfg_t        c;
        logic [31:0] r;
        r           = xorshift();
        tag         = id_width'(r % num_col);
        c           = '0;
        c.flush_tag = 1'b1;
        c.tag       = tag;
        drive(c, '0);
    endtask

    // flush then kernel_size weights with optional bus words that must be lost
    task automatic load_kernel(input int ks, input bit lose_words);
        cfg_t        c;
        bus_word_t   w;
        logic [31:0] r;
        int          i;
        c              = '0;
        c.flush_kernel = 1'b1;
        c.kernel_size  = ksize_width'(ks);
        drive(c, '0);
        idle(1);
        wait_ready(1'b0);
        for (i = 0; i < ks; i++) begin
            r            = xorshift();
            c            = '0;
            c.fltr_valid = 1'b1;
            c.fltr_data  = r[data_width-1:0];
            w            = lose_words ? make_word(r[20] ? PKT_PSUM : PKT_IFMAP, tag) : '0;
            drive(c, w);
        end
        idle(1);
        wait_ready(1'b1);
    endtask

    // psum word then ks ifmaps with foreign words mixed in on request
    task automatic run_window(input int ks, input int mode, input bit foreign);
        logic [31:0] r;
        int          i;
        drive('0, make_word(PKT_PSUM, pick_id(mode)));
        i = 0;
        while (i < ks) begin
            r = xorshift();
            if (foreign && r[3]) begin
                drive('0, make_word(r[9] ? PKT_PSUM : PKT_IFMAP, foreign_id()));
            end else begin
                drive('0, make_word(PKT_IFMAP, pick_id(mode)));
                i++;
            end
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [31:0] r;
        clk       = 1'b0;
        rstn      = 1'b0;
        cfg       = '0;
        bus_in    = '0;
        tag       = '0;
        rng_state = 32'd23;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // nothing accepted before configuration
        u_checker.start_test("reset_idle");
        idle(2);
        repeat (4) drive('0, make_word(PKT_IFMAP, pick_id(1)));
        configure_tag();
        repeat (4) drive('0, make_word(PKT_IFMAP, pick_id(2)));
        idle(4);
        u_checker.finish_test();

        u_checker.start_test("config_single_window");
        r = xorshift();
        k = 1 + int'(r % wbuf_depth);
        load_kernel(k, 1'b0);
        run_window(k, 0, 1'b0);
        idle(1);
        wait_drained();
        u_checker.finish_test();

        u_checker.start_test("foreign_ids");
        repeat (3) run_window(k, 0, 1'b1);
        idle(1);
        wait_drained();
        u_checker.finish_test();

        u_checker.start_test("broadcast_ids");
        repeat (2) run_window(k, 1, 1'b0);
        run_window(k, 2, 1'b1);
        idle(1);
        wait_drained();
        u_checker.finish_test();

        // back to back windows then an abandoned partial window
        u_checker.start_test("circular_replay");
        repeat (4) run_window(k, 2, 1'b0);
        drive('0, make_word(PKT_PSUM, tag));
        r = xorshift();
        // at least one ifmap and never a full window
        repeat ((k > 1) ? 1 + int'(r % (k - 1)) : 0) begin
            drive('0, make_word(PKT_IFMAP, pick_id(2)));
        end
        repeat (2) run_window(k, 2, 1'b0);
        idle(1);
        wait_drained();
        u_checker.finish_test();

        u_checker.start_test("kernel_reload");
        r = xorshift();
        k = 1 + int'(r % wbuf_depth);
        load_kernel(k, 1'b1);
        repeat (3) run_window(k, 2, 1'b1);
        idle(1);
        wait_drained();
        u_checker.finish_test();

        // room for stray pulses to show up
        idle(4);
        u_checker.report_summary();
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb/pe_slot_checker.sv
module pe_slot_checker import pe_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  cfg_t                  cfg,
    input  bus_word_t             bus_in,
    input  logic                  ready,
    input  logic                  kernel_busy,
    input  logic                  result_valid,
    input  logic [psum_width-1:0] result_psum,
    output int                    pending,
    output int                    error_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // slot model
    logic [id_width-1:0]          m_tag;
    logic                         m_lock;
    logic [ksize_width-1:0]       m_ksize;
    wb_state_t                    m_state;
    logic [data_width-1:0]        m_weights [wbuf_depth];
    int                           wr_cnt;
    int                           rd_idx;
    int                           win_cnt;
    logic [psum_width-1:0]        m_acc;
    logic [psum_width-1:0]        expect_q [$];
    logic                         size_ok;
    logic                         m_ready;
    logic                         m_busy;
    logic signed [psum_width-1:0] prod;
    logic [psum_width-1:0]        exp_psum;

    // edge count for result latency
    int                           cycle;
    int                           due_q [$];
    int                           due;

    // per test bookkeeping
    string test_name;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;

    initial begin
        test_name    = "startup";
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        error_count  = 0;
        pending      = 0;
        cycle        = 0;
    end

    task automatic value_error(input string what, input logic [psum_width-1:0] exp_v,
                               input logic [psum_width-1:0] act_v);
        $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        test_errors++;
        error_count++;
    endtask

    task automatic plain_error(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("[PASS] %s", test_name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report_summary();
        $display("summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
    endtask

    //////////////////////////////
    // compare then step the model
    //////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            m_tag   = '0;
            m_lock  = 1'b0;
            m_ksize = '0;
            m_state = WB_EMPTY;
            wr_cnt  = 0;
            rd_idx  = 0;
            win_cnt = 0;
            m_acc   = '0;
            expect_q.delete();
            due_q.delete();
        end else begin
            cycle   = cycle + 1;
            size_ok = (m_ksize != 0) && (m_ksize <= wbuf_depth);
            m_busy  = (m_state == WB_LOADING) && size_ok;
            m_ready = m_lock && (m_state == WB_READY);
            if (ready !== m_ready) value_error("ready", m_ready, ready);
            if (kernel_busy !== m_busy) value_error("kernel_busy", m_busy, kernel_busy);

            // results leave in acceptance order
            if (result_valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    plain_error("result_valid pulsed with no result outstanding");
                end else begin
                    exp_psum = expect_q.pop_front();
                    due      = due_q.pop_front();
                    if (result_psum !== exp_psum) begin
                        value_error("result_psum", exp_psum, result_psum);
                    end
                    // two edges after the accepting one
                    if (cycle != due) begin
                        value_error("result latency", 2, 2 + cycle - due);
                    end
                end
            end else if (result_valid !== 1'b0) begin
                plain_error("result_valid is unknown");
            end

            // own tag or broadcast and only while ready
            if (bus_in.valid && m_ready && (bus_in.id == m_tag || bus_in.id[id_width-1])) begin
                if (bus_in.kind == PKT_PSUM) begin
                    m_acc   = bus_in.psum;
                    win_cnt = 0;
                    rd_idx  = 0;
                end else begin
                    prod    = $signed(bus_in.ifmap) * $signed(m_weights[rd_idx]);
                    m_acc   = m_acc + prod;
                    rd_idx  = (rd_idx + 1) % m_ksize;
                    win_cnt = win_cnt + 1;
                    if (win_cnt == m_ksize) begin
                        expect_q.push_back(m_acc);
                        due_q.push_back(cycle + 2);
                        win_cnt = 0;
                    end
                end
            end

            if (cfg.flush_tag) begin
                m_tag  = cfg.tag;
                m_lock = 1'b1;
            end
            // weights in the flush cycle itself do not count
            if (cfg.flush_kernel) begin
                m_ksize = cfg.kernel_size;
                m_state = WB_LOADING;
                wr_cnt  = 0;
                rd_idx  = 0;
            end else if (m_state == WB_LOADING) begin
                if (!size_ok) begin
                    m_state = WB_EMPTY;
                end else if (cfg.fltr_valid) begin
                    m_weights[wr_cnt] = cfg.fltr_data;
                    wr_cnt = wr_cnt + 1;
                    if (wr_cnt == m_ksize) m_state = WB_READY;
                end
            end
        end
        pending = expect_q.size();
    end

endmodule

// File: hw/pe_slot_top.sv
module pe_slot_top import pe_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  cfg_t                  cfg,
    input  bus_word_t             bus_in,
    output logic                  ready,
    output logic                  kernel_busy,
    output logic                  result_valid,
    output logic [psum_width-1:0] result_psum
);

    // multicaster to weight buffer
    wb_state_t              buf_state;
    logic                   wr_en;
    logic [data_width-1:0]  wr_data;
    logic                   flush_kernel;
    logic [ksize_width-1:0] kernel_size;
    logic                   rd_en;
    logic                   rewind;

    // weight buffer and multicaster to pe
    logic [data_width-1:0]  weight;
    pe_op_t                 pe_op;

    //////////////////////////////
    // producer
    //////////////////////////////

    multicaster u_multicaster (
        .clk          (clk),
        .rstn         (rstn),
        .cfg          (cfg),
        .bus_in       (bus_in),
        .buf_state    (buf_state),
        .ready        (ready),
        .kernel_busy  (kernel_busy),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .flush_kernel (flush_kernel),
        .kernel_size  (kernel_size),
        .rd_en        (rd_en),
        .rewind       (rewind),
        .pe_op        (pe_op)
    );

    //////////////////////////////
    // buffer
    //////////////////////////////

    weight_buffer u_weight_buffer (
        .clk          (clk),
        .rstn         (rstn),
        .flush_kernel (flush_kernel),
        .kernel_size  (kernel_size),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rewind       (rewind),
        .weight       (weight),
        .buf_state    (buf_state)
    );

    //////////////////////////////
    // consumer
    //////////////////////////////

    pe_mac u_pe_mac (
        .clk          (clk),
        .rstn         (rstn),
        .pe_op        (pe_op),
        .weight       (weight),
        .kernel_size  (kernel_size),
        .result_valid (result_valid),
        .result_psum  (result_psum)
    );

endmodule

// File: hw/pe_mac.sv
module pe_mac import pe_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  pe_op_t                 pe_op,
    input  logic [data_width-1:0]  weight,
    input  logic [ksize_width-1:0] kernel_size,
    output logic                   result_valid,
    output logic [psum_width-1:0]  result_psum
);

    logic [psum_width-1:0]          acc_q;
    logic [ksize_width-1:0]         win_cnt;
    logic [ksize_width-1:0]         ksize_last;
    logic signed [2*data_width-1:0] prod;
    logic signed [psum_width-1:0]   prod_ext;
    logic                           do_psum;
    logic                           do_ifmap;
    logic                           win_end;

    //////////////////////////////
    // operation decode
    //////////////////////////////

    assign do_psum  = pe_op.op_valid && (pe_op.kind == PKT_PSUM);
    assign do_ifmap = pe_op.op_valid && (pe_op.kind == PKT_IFMAP);

    // last ifmap of the window
    assign ksize_last = kernel_size - 1'b1;
    assign win_end    = (win_cnt == ksize_last);

    //////////////////////////////
    // signed multiply
    //////////////////////////////

    // weight arrives alongside the op
    assign prod = $signed(pe_op.ifmap) * $signed(weight);

    // sign extend up to psum width
    assign prod_ext = psum_width'(prod);

    //////////////////////////////
    // accumulator and window count
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_q        <= '0;
            win_cnt      <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (do_psum) begin
                // load incoming partial sum, fresh window
                acc_q   <= pe_op.psum;
                win_cnt <= '0;
            end else if (do_ifmap) begin
                // wraps modulo 2^psum_width
                acc_q <= acc_q + prod_ext;
                if (win_end) begin
                    win_cnt      <= '0;
                    result_valid <= 1'b1;
                end else begin
                    win_cnt <= win_cnt + 1'b1;
                end
            end
        end
    end

    // accumulator keeps its value after the window closes
    assign result_psum = acc_q;

endmodule

// File: hw/weight_buffer.sv
module weight_buffer import pe_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush_kernel,
    input  logic [ksize_width-1:0] kernel_size,
    input  logic                   wr_en,
    input  logic [data_width-1:0]  wr_data,
    input  logic                   rd_en,
    input  logic                   rewind,
    output logic [data_width-1:0]  weight,
    output wb_state_t              buf_state
);

    logic [data_width-1:0]     mem [wbuf_depth];
    logic [wbuf_ptr_width-1:0] wr_ptr;
    logic [wbuf_ptr_width-1:0] rd_ptr;
    logic [ksize_width-1:0]    ksize_last;
    logic                      load_we;
    logic                      wr_last;
    logic                      rd_last;

    // index of the final kernel entry
    assign ksize_last = kernel_size - 1'b1;

    assign wr_last = (ksize_width'(wr_ptr) == ksize_last);
    assign rd_last = (ksize_width'(rd_ptr) == ksize_last);

    // writes count only while loading a usable kernel
    // a strobe in the flush cycle itself is ignored
    assign load_we = wr_en && !flush_kernel && (buf_state == WB_LOADING)
                     && ksize_valid(kernel_size);

    //////////////////////////////
    // load fsm and pointers
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_state <= WB_EMPTY;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end else if (flush_kernel) begin
            // restart loading from entry 0
            buf_state <= WB_LOADING;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end else begin
            case (buf_state)
                WB_LOADING: begin
                    if (!ksize_valid(kernel_size)) begin
                        buf_state <= WB_EMPTY;
                    end else if (load_we) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (wr_last) begin
                            buf_state <= WB_READY;
                        end
                    end
                end
                WB_READY: begin
                    // circular replay over kernel_size entries
                    if (rewind) begin
                        rd_ptr <= '0;
                    end else if (rd_en) begin
                        rd_ptr <= rd_last ? '0 : rd_ptr + 1'b1;
                    end
                end
                default: begin
                    // empty, wait for the next flush
                end
            endcase
        end
    end

    //////////////////////////////
    // storage and read port
    //////////////////////////////

    // registered read, weight valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            weight <= mem[rd_ptr];
        end
    end

endmodule

// File: hw/multicaster.sv
module multicaster import pe_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  cfg_t                   cfg,
    input  bus_word_t              bus_in,
    input  wb_state_t              buf_state,
    output logic                   ready,
    output logic                   kernel_busy,
    output logic                   wr_en,
    output logic [data_width-1:0]  wr_data,
    output logic                   flush_kernel,
    output logic [ksize_width-1:0] kernel_size,
    output logic                   rd_en,
    output logic                   rewind,
    output pe_op_t                 pe_op
);

    //////////////////////////////
    // tag register
    //////////////////////////////

    logic [id_width-1:0] tag_q;
    logic                tag_lock;

    // lock stays set until reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag_q    <= '0;
            tag_lock <= 1'b0;
        end else if (cfg.flush_tag) begin
            tag_q    <= cfg.tag;
            tag_lock <= 1'b1;
        end
    end

    //////////////////////////////
    // kernel size register
    //////////////////////////////

    logic [ksize_width-1:0] ksize_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ksize_q <= '0;
        end else if (cfg.flush_kernel) begin
            ksize_q <= cfg.kernel_size;
        end
    end

    assign kernel_size = ksize_q;

    // flush goes straight through, buffer restarts on the same edge
    assign flush_kernel = cfg.flush_kernel;

    // filter weights straight to the store
    assign wr_en   = cfg.fltr_valid;
    assign wr_data = cfg.fltr_data;

    //////////////////////////////
    // readiness
    //////////////////////////////

    // busy only while a usable kernel is loading
    // an invalid size drops the buffer to empty, never busy
    assign kernel_busy = (buf_state == WB_LOADING) && ksize_valid(ksize_q);

    assign ready = tag_lock && !kernel_busy && (buf_state == WB_READY);

    //////////////////////////////
    // id match and acceptance
    //////////////////////////////

    logic id_match;
    logic bcast;
    logic accept;

    // top id bit means every column
    assign bcast    = bus_in.id[id_width-1];
    assign id_match = (bus_in.id == tag_q) || bcast;
    assign accept   = bus_in.valid && ready && id_match;

    // weight read lines up with the ifmap, one cycle later at the pe
    assign rd_en = accept && (bus_in.kind == PKT_IFMAP);

    // psum starts a fresh window, replay from entry 0
    assign rewind = accept && (bus_in.kind == PKT_PSUM);

    //////////////////////////////
    // operation register to pe
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pe_op <= '0;
        end else begin
            pe_op.op_valid <= accept;
            // payload follows only on acceptance
            if (accept) begin
                pe_op.kind  <= bus_in.kind;
                pe_op.ifmap <= bus_in.ifmap;
                pe_op.psum  <= bus_in.psum;
            end
        end
    end

endmodule

// File: hw/pe_pkg.sv
package pe_pkg;

    //////////////////////////////
    // widths and depths
    //////////////////////////////

    // ifmap values and filter weights
    localparam int data_width = 16;
    // partial sums
    localparam int psum_width = 32;
    // columns sharing the bus
    localparam int num_col = 4;
    // column index plus broadcast bit on top
    localparam int id_width = $clog2(num_col) + 1;
    // weight store entries
    localparam int wbuf_depth = 16;
    localparam int wbuf_ptr_width = $clog2(wbuf_depth);
    // kernel size field on the config bus
    localparam int ksize_width = 8;

    //////////////////////////////
    // enums
    //////////////////////////////

    // data-path word kind
    typedef enum logic {
        PKT_IFMAP,
        PKT_PSUM
    } pkt_kind_t;

    // weight buffer fsm
    typedef enum logic [1:0] {
        WB_EMPTY,
        WB_LOADING,
        WB_READY
    } wb_state_t;

    //////////////////////////////
    // structs
    //////////////////////////////

    // one data-path word on the shared bus
    typedef struct packed {
        logic                  valid;
        pkt_kind_t             kind;
        logic [id_width-1:0]   id;
        logic [data_width-1:0] ifmap;
        logic [psum_width-1:0] psum;
    } bus_word_t;

    // configuration strobes with their payload
    typedef struct packed {
        logic                   flush_tag;
        logic [id_width-1:0]    tag;
        logic                   flush_kernel;
        logic [ksize_width-1:0] kernel_size;
        logic                   fltr_valid;
        logic [data_width-1:0]  fltr_data;
    } cfg_t;

    // accepted operation handed to the pe
    typedef struct packed {
        logic                  op_valid;
        pkt_kind_t             kind;
        logic [data_width-1:0] ifmap;
        logic [psum_width-1:0] psum;
    } pe_op_t;

    // kernel size must fit the weight store and be nonzero
    function automatic logic ksize_valid(input logic [ksize_width-1:0] k);
        return (k != '0) && (k <= ksize_width'(wbuf_depth));
    endfunction

endpackage
